//--- design/tft_pkg.sv
// TFT controller shared definitions
`default_nettype none

package tft_pkg;

    // Horizontal regions in pixel periods, in scan order after the active area
    localparam int H_ACTIVE = 8;
    localparam int H_FRONT  = 2;
    localparam int H_SYNC   = 2;
    localparam int H_BACK   = 2;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // 14 pixels per line

    // Vertical regions in whole lines
    localparam int V_ACTIVE = 4;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 1;
    localparam int V_BACK   = 1;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // 7 lines per frame

    localparam int H_CNT_W  = $clog2(H_TOTAL); // Wide enough for 0 to H_TOTAL-1
    localparam int V_CNT_W  = $clog2(V_TOTAL); // Wide enough for 0 to V_TOTAL-1

    // Pixel buffer size, which is also the number of credits the source starts with
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // RGB565 pixel word
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pixel_t;

    // One credit-governed write from the frame source
    typedef struct packed {
        logic   valid;
        pixel_t pixel;
    } pixel_in_t;

    // Position flags for the pixel currently being launched
    typedef struct packed {
        logic active;      // Inside the visible window
        logic hsync;
        logic vsync;
        logic frame_start; // Pixel 0 of line 0
    } timing_t;

    // Everything the panel connector sees
    typedef struct packed {
        logic   pclk;
        logic   hsync;
        logic   vsync;
        logic   de;
        pixel_t rgb;
    } tft_pins_t;

endpackage

`default_nettype wire

//--- design/tft_pclk_gen.sv
// Panel pixel clock divider
`timescale 1ns/1ps
`default_nettype none

module tft_pclk_gen (
    input  wire        clk,
    input  wire        rst,
    input  wire [15:0] clock_divide, // Half period minus one, in clk cycles
    output logic       pclk,
    output logic       pclk_en
);

    // Cycles left in the current half period
    logic [15:0] delay;
    logic        reload; // Half period ends on this cycle

    assign reload = (delay == 16'd0);

    // The divisor is sampled only at a reload, so a change mid half period
    // takes effect from the next half period onward
    always_ff @(posedge clk) begin
        if (rst) begin
            delay <= 16'd0;
            pclk  <= 1'b1; // Comes out of reset high so the first toggle is a fall
        end else if (reload) begin
            pclk  <= ~pclk;        // Flip the level at every half period boundary
            delay <= clock_divide; // Start counting the next half period
        end else begin
            delay <= delay - 16'd1;
        end
    end

    // A reload while pclk is low is the cycle just before the rising edge
    // Downstream logic uses this as its single-cycle pixel strobe
    assign pclk_en = reload & ~pclk;

    // With clock_divide at 0 the pixel clock runs at half the clk rate
    // and pclk_en fires on every second cycle
    // Larger divisors stretch both halves equally, giving a 50 percent duty cycle
    // The counter is a plain down-counter so the full 16-bit range is usable

endmodule

`default_nettype wire

//--- design/tft_pixel_fifo.sv
// Credit-returning pixel FIFO
`timescale 1ns/1ps
`default_nettype none

module tft_pixel_fifo (
    input  wire                     clk,
    input  wire                     rst,
    input  wire tft_pkg::pixel_in_t pixel_in, // Write from the frame source
    input  wire                     pop,      // Scanout consumed the head word
    output tft_pkg::pixel_t         head,     // Oldest stored pixel, fall-through
    output logic                    empty,
    output logic                    credit    // One pulse per freed entry
);

    // Storage array with no reset since only entries below count are ever read
    tft_pkg::pixel_t mem [tft_pkg::FIFO_DEPTH];

    logic [tft_pkg::FIFO_AW-1:0] wr_ptr; // Next slot to fill
    logic [tft_pkg::FIFO_AW-1:0] rd_ptr; // Slot holding the head word
    logic [tft_pkg::FIFO_AW:0]   count;  // Occupancy, one bit wider than the pointers

    logic push;

    // The source only writes while it holds a credit, so a full FIFO never sees a push
    assign push = pixel_in.valid;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= pixel_in.pixel;
        end
    end

    // Pointers wrap on their own because the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy tracks push and pop together so a simultaneous pair leaves it alone
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Idle or push and pop together
            endcase
        end
    end

    // Each pop frees exactly one entry and hands one credit back a cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            credit <= 1'b0;
        end else begin
            credit <= pop;
        end
    end

    assign head  = mem[rd_ptr]; // Valid whenever empty is low
    assign empty = (count == '0);

endmodule

`default_nettype wire

//--- design/tft_timing_gen.sv
// Panel raster timing generator
`timescale 1ns/1ps
`default_nettype none

module tft_timing_gen (
    input  wire              clk,
    input  wire              rst,
    input  wire              pclk_en, // Advance one pixel position
    output tft_pkg::timing_t timing
);

    // Last count values before each counter wraps
    localparam logic [tft_pkg::H_CNT_W-1:0] H_LAST =
        tft_pkg::H_CNT_W'(tft_pkg::H_TOTAL - 1);
    localparam logic [tft_pkg::V_CNT_W-1:0] V_LAST =
        tft_pkg::V_CNT_W'(tft_pkg::V_TOTAL - 1);

    // Region boundaries in counter units
    localparam logic [tft_pkg::H_CNT_W-1:0] H_ACT_END =
        tft_pkg::H_CNT_W'(tft_pkg::H_ACTIVE);
    localparam logic [tft_pkg::H_CNT_W-1:0] H_SYNC_BEG =
        tft_pkg::H_CNT_W'(tft_pkg::H_ACTIVE + tft_pkg::H_FRONT);
    localparam logic [tft_pkg::H_CNT_W-1:0] H_SYNC_END =
        tft_pkg::H_CNT_W'(tft_pkg::H_ACTIVE + tft_pkg::H_FRONT + tft_pkg::H_SYNC);
    localparam logic [tft_pkg::V_CNT_W-1:0] V_ACT_END =
        tft_pkg::V_CNT_W'(tft_pkg::V_ACTIVE);
    localparam logic [tft_pkg::V_CNT_W-1:0] V_SYNC_BEG =
        tft_pkg::V_CNT_W'(tft_pkg::V_ACTIVE + tft_pkg::V_FRONT);
    localparam logic [tft_pkg::V_CNT_W-1:0] V_SYNC_END =
        tft_pkg::V_CNT_W'(tft_pkg::V_ACTIVE + tft_pkg::V_FRONT + tft_pkg::V_SYNC);

    logic [tft_pkg::H_CNT_W-1:0] h_count; // Pixel within the line
    logic [tft_pkg::V_CNT_W-1:0] v_count; // Line within the frame
    logic                        line_end;

    assign line_end = (h_count == H_LAST);

    // Counts hold the position of the pixel that the next strobe launches
    always_ff @(posedge clk) begin
        if (rst) begin
            h_count <= '0;
        end else if (pclk_en) begin
            if (line_end) begin
                h_count <= '0;
            end else begin
                h_count <= h_count + 1'b1;
            end
        end
    end

    // The line counter moves only when the last pixel of a line goes out
    always_ff @(posedge clk) begin
        if (rst) begin
            v_count <= '0;
        end else if (pclk_en && line_end) begin
            if (v_count == V_LAST) begin
                v_count <= '0; // Frame wraps back to the first visible line
            end else begin
                v_count <= v_count + 1'b1;
            end
        end
    end

    logic h_vis;
    logic v_vis;
    logic h_sync_zone;
    logic v_sync_zone;

    // Active area sits at the start of both counters with porches and sync after it
    assign h_vis       = (h_count < H_ACT_END);
    assign v_vis       = (v_count < V_ACT_END);
    assign h_sync_zone = (h_count >= H_SYNC_BEG) && (h_count < H_SYNC_END);
    assign v_sync_zone = (v_count >= V_SYNC_BEG) && (v_count < V_SYNC_END); // Whole lines

    always_comb begin
        timing.active      = h_vis & v_vis;
        timing.hsync       = h_sync_zone;
        timing.vsync       = v_sync_zone;
        timing.frame_start = (h_count == '0) && (v_count == '0);
    end

endmodule

`default_nettype wire

//--- design/tft_scanout.sv
// Panel pin driver and pixel scanout
`timescale 1ns/1ps
`default_nettype none

module tft_scanout (
    input  wire               clk,
    input  wire               rst,
    input  wire               pclk,      // Divided clock from the generator flop
    input  wire               pclk_en,   // Cycle before the pixel clock rises
    input  wire tft_pkg::timing_t timing, // Position of the pixel being launched
    input  wire tft_pkg::pixel_t  head,   // FIFO head word
    input  wire               empty,
    output logic              pop,
    output tft_pkg::tft_pins_t pins,
    output logic              underflow  // Sticky until reset
);

    logic            take;    // Active position with a pixel ready
    logic            starved; // Active position with nothing to show

    // Registered panel pins apart from the clock
    logic            pin_hsync;
    logic            pin_vsync;
    logic            pin_de;
    tft_pkg::pixel_t pin_rgb;

    assign take    = pclk_en & timing.active & ~empty;
    assign starved = pclk_en & timing.active & empty;

    // The head word is consumed on the same edge that latches it onto the pins
    assign pop = take;

    always_ff @(posedge clk) begin
        if (rst) begin
            pin_hsync <= 1'b0;
            pin_vsync <= 1'b0;
            pin_de    <= 1'b0;
            pin_rgb   <= '0;
        end else if (pclk_en) begin
            pin_hsync <= timing.hsync;
            pin_vsync <= timing.vsync;
            pin_de    <= timing.active; // Stays high through an underflow
            if (take) begin
                pin_rgb <= head;
            end else begin
                pin_rgb <= '0; // Black in blanking and when the FIFO ran dry
            end
        end
    end

    // Once the panel has shown a black fill pixel the flag stays up until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            underflow <= 1'b0;
        end else if (starved) begin
            underflow <= 1'b1;
        end
    end

    // The pixel clock pin is taken from the generator flop so that it rises on the
    // same clk edge that updates the data pins, leaving a full half period of
    // setup before the falling edge on which the panel samples
    always_comb begin
        pins.pclk  = pclk;
        pins.hsync = pin_hsync;
        pins.vsync = pin_vsync;
        pins.de    = pin_de;
        pins.rgb   = pin_rgb;
    end

endmodule

`default_nettype wire

//--- design/tft_controller.sv
// TFT panel controller top level
`timescale 1ns/1ps
`default_nettype none

module tft_controller (
    input  wire                     clk,
    input  wire                     rst,
    input  wire [15:0]              clock_divide, // Pixel clock half period minus one
    input  wire tft_pkg::pixel_in_t pixel_in,     // Credit-governed pixel writes
    output logic                    credit,       // One pulse per freed FIFO entry
    output tft_pkg::tft_pins_t      pins,         // Panel connector
    output logic                    underflow
);

    logic             pclk;    // Divided panel clock
    logic             pclk_en; // Pixel strobe in the clk domain
    tft_pkg::timing_t timing;
    logic             pop;
    tft_pkg::pixel_t  head;
    logic             empty;

    // Divider sets the pace for everything downstream
    tft_pclk_gen u_pclk_gen (
        .clk          (clk),
        .rst          (rst),
        .clock_divide (clock_divide),
        .pclk         (pclk),
        .pclk_en      (pclk_en)
    );

    tft_pixel_fifo u_fifo (
        .clk      (clk),
        .rst      (rst),
        .pixel_in (pixel_in),
        .pop      (pop),
        .head     (head),
        .empty    (empty),
        .credit   (credit)
    );

    tft_timing_gen u_timing (
        .clk     (clk),
        .rst     (rst),
        .pclk_en (pclk_en),
        .timing  (timing)
    );

    // Scanout drains the FIFO in step with the raster
    tft_scanout u_scanout (
        .clk       (clk),
        .rst       (rst),
        .pclk      (pclk),
        .pclk_en   (pclk_en),
        .timing    (timing),
        .head      (head),
        .empty     (empty),
        .pop       (pop),
        .pins      (pins),
        .underflow (underflow)
    );

endmodule

`default_nettype wire

//--- testbench/tft_controller_assert.sv
// TFT controller protocol checks
`timescale 1ns/1ps
`default_nettype none

module tft_controller_assert (
    input wire                     clk,
    input wire                     rst,
    input wire tft_pkg::pixel_in_t pixel_in,
    input wire                     pop,
    input wire                     credit,
    input wire tft_pkg::tft_pins_t pins,
    input wire                     underflow
);

    int occupancy;    // FIFO fill rebuilt from the write and pop strobes
    int failures = 0; // Read by the testbench for its summary

    always_ff @(posedge clk) begin
        if (rst) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(pixel_in.valid) - int'(pop);
        end
    end

    assert property (@(posedge clk) disable iff (rst) occupancy <= tft_pkg::FIFO_DEPTH)
        else begin
            failures++;
            $error("pixel FIFO holds more than its depth");
        end

    // The source may only write while it still holds a credit
    assert property (@(posedge clk) disable iff (rst)
        pixel_in.valid |-> occupancy < tft_pkg::FIFO_DEPTH)
        else begin
            failures++;
            $error("pixel write arrived while the FIFO was full");
        end

    assert property (@(posedge clk) disable iff (rst) !pop |=> !credit)
        else begin
            failures++;
            $error("credit returned without a pop");
        end

    assert property (@(posedge clk) disable iff (rst) pins.de |-> !(pins.hsync || pins.vsync))
        else begin
            failures++;
            $error("data enable overlaps a sync pulse");
        end

    // Underflow is sticky and only a reset clears it
    assert property (@(posedge clk) disable iff (rst) $fell(underflow) |-> $past(rst))
        else begin
            failures++;
            $error("underflow cleared without a reset");
        end

endmodule

bind tft_controller tft_controller_assert i_assert (
    .clk       (clk),
    .rst       (rst),
    .pixel_in  (pixel_in),
    .pop       (pop),
    .credit    (credit),
    .pins      (pins),
    .underflow (underflow)
);

`default_nettype wire

//--- testbench/tb_tft_controller.sv
// TFT controller testbench
`timescale 1ns/1ps
`default_nettype none

module tb_tft_controller;

    localparam int FRAMES     = 2;
    localparam int FRAME_PIX  = tft_pkg::H_TOTAL * tft_pkg::V_TOTAL; // Pixel periods per frame
    localparam int FRAME_DE   = tft_pkg::H_ACTIVE * tft_pkg::V_ACTIVE; // Visible pixels per frame
    localparam int STOP_AFTER = 20; // Pixels written in the underflow run
    // Each run is FRAMES frames at 2*(divisor+1) clk cycles per pixel, for divisors 0, 3 and 1
    localparam int RUN_CYCLES = FRAMES * FRAME_PIX * (2 * (0 + 1) + 2 * (3 + 1) + 2 * (1 + 1));
    localparam int TIMEOUT_NS = RUN_CYCLES * 4 * 3 / 2; // 4 ns clock plus half again

    logic               clk = 1'b0;
    logic               rst;
    logic [15:0]        clock_divide;
    tft_pkg::pixel_in_t pixel_in;
    logic               credit;
    tft_pkg::tft_pins_t pins;
    logic               underflow;

    int run_divisor = 0; // Divisor of the current run
    int pixel_limit = 0; // Pixels the source writes in the current run

    // Checker state, all cleared while reset is high
    logic prev_pclk;
    logic rise_seen;
    logic starved_seen; // A visible pixel found the FIFO dry
    int   cycle_count;
    int   last_rise;
    int   h_pos;
    int   v_pos;
    int   de_index;    // Running index of de-high pixels
    int   checked = 0; // Pixel periods compared so far
    int   taken;       // De-high pixels that carried real data

    // Source state
    int credits;
    int credits_back;
    int sent;
    int pause;

    int value_errors    = 0;
    int protocol_errors = 0;

    tft_controller i_dut (
        .clk          (clk),
        .rst          (rst),
        .clock_divide (clock_divide),
        .pixel_in     (pixel_in),
        .credit       (credit),
        .pins         (pins),
        .underflow    (underflow)
    );

    always #2 clk = ~clk;

    // Pixel n of the stream, independent of frame position
    function automatic tft_pkg::pixel_t pattern_pixel(input int n);
        tft_pkg::pixel_t p;
        p.red   = 5'(n);
        p.green = 6'(n * 3 + 11);
        p.blue  = 5'((n >> 1) ^ 21);
        return p;
    endfunction

    // Pins the panel should see for position h, v when the k-th visible pixel is due
    function automatic tft_pkg::tft_pins_t expected_pins(input int h, input int v,
                                                         input int k, input int limit);
        tft_pkg::tft_pins_t p;
        p       = '0; // Pixel clock is low when the panel samples
        p.de    = (h < tft_pkg::H_ACTIVE) && (v < tft_pkg::V_ACTIVE);
        p.hsync = (h >= tft_pkg::H_ACTIVE + tft_pkg::H_FRONT) &&
                  (h < tft_pkg::H_ACTIVE + tft_pkg::H_FRONT + tft_pkg::H_SYNC);
        p.vsync = (v >= tft_pkg::V_ACTIVE + tft_pkg::V_FRONT) &&
                  (v < tft_pkg::V_ACTIVE + tft_pkg::V_FRONT + tft_pkg::V_SYNC);
        if (p.de && k < limit) begin
            p.rgb = pattern_pixel(k); // Black once the source has run out
        end
        return p;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    // Compare one sampled pixel period, then step the expected raster position
    task automatic check_pixel();
        tft_pkg::tft_pins_t exp;
        exp = expected_pins(h_pos, v_pos, de_index, pixel_limit);
        if (exp.de && de_index >= pixel_limit) begin
            starved_seen = 1'b1; // Flag must be up from this pixel on
        end
        check_value("pins.de", 32'(exp.de), 32'(pins.de));
        check_value("pins.hsync", 32'(exp.hsync), 32'(pins.hsync));
        check_value("pins.vsync", 32'(exp.vsync), 32'(pins.vsync));
        check_value("pins.rgb", 32'(exp.rgb), 32'(pins.rgb));
        check_value("underflow", 32'(starved_seen), 32'(underflow));
        if (exp.de) begin
            if (de_index < pixel_limit) begin
                taken++;
            end
            de_index++;
        end
        if (h_pos == tft_pkg::H_TOTAL - 1) begin
            h_pos = 0;
            v_pos = (v_pos == tft_pkg::V_TOTAL - 1) ? 0 : v_pos + 1;
        end else begin
            h_pos++;
        end
        checked++;
    endtask

    // Everything changes on the rising clk edge, so the falling edge sees settled pins
    always @(negedge clk) begin
        if (rst) begin
            rise_seen    = 1'b0;
            starved_seen = 1'b0;
            cycle_count  = 0;
            last_rise    = 0;
            h_pos        = 0;
            v_pos        = 0;
            de_index     = 0;
            checked      = 0;
            taken        = 0;
        end else begin
            cycle_count++;
            if (!prev_pclk && pins.pclk) begin
                if (rise_seen) begin
                    check_value("pins.pclk period", 32'(2 * (run_divisor + 1)),
                                32'(cycle_count - last_rise));
                end
                rise_seen = 1'b1; // A pixel has been launched
                last_rise = cycle_count;
            end else if (prev_pclk && !pins.pclk && rise_seen) begin
                check_pixel(); // Panel sampling edge
            end
        end
        prev_pclk = pins.pclk;
    end

    // Reset, then act as the credit-honouring source until two frames are checked
    task automatic run_stream(input logic [15:0] divisor, input int limit);
        int target;
        target = FRAMES * FRAME_PIX;
        @(posedge clk);
        #1;
        rst          = 1'b1;
        clock_divide = divisor;
        pixel_in     = '0;
        run_divisor  = int'(divisor);
        pixel_limit  = limit;
        credits      = tft_pkg::FIFO_DEPTH;
        credits_back = 0;
        sent         = 0;
        pause        = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        while (checked < target) begin
            if (credit) begin
                credits++;
                credits_back++;
            end
            assert (credits <= tft_pkg::FIFO_DEPTH) else begin
                protocol_errors++;
                $display("credit counter rose above the FIFO depth at %0t", $time);
            end
            pixel_in = '0;
            if (pause > 0) begin
                pause--;
            end else if (sent < limit && credits > 0) begin
                pixel_in.valid = 1'b1;
                pixel_in.pixel = pattern_pixel(sent);
                sent++;
                credits--;
                // Only idle while the FIFO holds enough to ride out the gap
                if (credits <= tft_pkg::FIFO_DEPTH / 2) begin
                    pause = $urandom_range(3, 0);
                end
            end
            @(posedge clk);
            #1;
        end
        pixel_in = '0;
        check_value("source credits", 32'(tft_pkg::FIFO_DEPTH), 32'(credits));
        check_value("credits returned", 32'(taken), 32'(credits_back));
    endtask

    initial begin
        int total_protocol;
        void'($urandom(28));
        rst          = 1'b1;
        clock_divide = 16'd0;
        pixel_in     = '0;
        run_stream(16'd0, FRAMES * FRAME_DE);
        run_stream(16'd3, FRAMES * FRAME_DE);
        run_stream(16'd1, STOP_AFTER); // Source dries up partway through the first frame
        total_protocol = protocol_errors + i_dut.i_assert.failures;
        $display("summary: %0d value errors, %0d protocol errors", value_errors, total_protocol);
        if (value_errors == 0 && total_protocol == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the runs did not finish within %0d ns", TIMEOUT_NS);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
design/tft_pkg.sv
design/tft_pclk_gen.sv
design/tft_pixel_fifo.sv
design/tft_timing_gen.sv
design/tft_scanout.sv
design/tft_controller.sv
testbench/tft_controller_assert.sv
testbench/tb_tft_controller.sv

//--- Makefile
# Verilator build and run for the TFT controller testbench

VERILATOR ?= verilator
TOP       ?= tb_tft_controller
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= sim passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
